// ==== logic/usb_loop_consts.svh ====
`ifndef USB_LOOP_CONSTS_SVH
`define USB_LOOP_CONSTS_SVH

// Width of one stream byte
`define USB_BYTE_W 8

// FIFO address bits, 2048 entries
`define USB_FIFO_ABITS 11

// Level must exceed this before the IN endpoint is ready
`define USB_IN_READY_MIN 4

// Level must stay below this for the OUT endpoint to be ready
`define USB_OUT_READY_MAX 1024

// Start-of-frame counter width
`define USB_SOF_CNT_W 24

// Number of board LEDs
`define USB_LED_W 4

`endif

// ==== logic/usb_loop_pkg.sv ====
`default_nettype none

`include "usb_loop_consts.svh"

package usb_loop_pkg;

  // One data byte on either endpoint
  typedef logic [`USB_BYTE_W-1:0] byte_t;

  // FIFO entry, end-of-packet flag on top of the byte
  typedef struct packed {
    logic  last;
    byte_t data;
  } fifo_word_t;

  // Occupancy 0..2048, one bit above the address
  typedef logic [`USB_FIFO_ABITS:0] level_t;

  // Holding state of the OUT register slice
  typedef enum logic {
    SLICE_EMPTY,
    SLICE_FULL
  } slice_state_e;

  // Blink pattern select
  typedef enum logic {
    LED_NORMAL,
    LED_CRC_FAULT
  } led_mode_e;

endpackage

`default_nettype wire

// ==== logic/byte_stream_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Valid/ready byte stream between the loop-back blocks
interface byte_stream_if
  import usb_loop_pkg::*;
();

  // Word moves when valid and ready are both high at the edge
  logic       valid;
  logic       ready;
  fifo_word_t word;

  // Producer side
  modport src (
    output valid,
    output word,
    input  ready
  );

  // Consumer side
  modport snk (
    input  valid,
    input  word,
    output ready
  );

endinterface

`default_nettype wire

// ==== logic/bulk_out_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module bulk_out_port
  import usb_loop_pkg::*;
(
  input  logic       clock,
  input  logic       usb_reset,
  input  logic       blk_cycle_i,
  input  logic       out_valid_i,
  input  logic       out_last_i,
  input  byte_t      out_data_i,
  output logic       out_ready_o,
  byte_stream_if.src wr
);

  slice_state_e state_q;
  fifo_word_t   word_q;
  logic         drain_w;
  logic         accept_w;

  // Slice empties this cycle when the FIFO takes the word
  assign drain_w = (state_q == SLICE_FULL) && wr.ready;

  // Room now or after the drain, only inside a bulk cycle
  assign out_ready_o = blk_cycle_i && ((state_q == SLICE_EMPTY) || drain_w);

  // Host byte handshake
  assign accept_w = out_valid_i && out_ready_o;

  // Holding state
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      state_q <= SLICE_EMPTY;
    end else if (accept_w) begin
      // Refill wins over a drain in the same cycle
      state_q <= SLICE_FULL;
    end else if (drain_w) begin
      state_q <= SLICE_EMPTY;
    end
  end

  // Payload capture
  always_ff @(posedge clock) begin
    if (accept_w) begin
      word_q.last <= out_last_i;
      word_q.data <= out_data_i;
    end
  end

  // Offer held word to the FIFO from the next cycle
  assign wr.valid = (state_q == SLICE_FULL);
  assign wr.word  = word_q;

endmodule

`default_nettype wire

// ==== logic/loopback_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_loop_consts.svh"

module loopback_fifo
  import usb_loop_pkg::*;
(
  input  logic       clock,
  input  logic       usb_reset,
  byte_stream_if.snk wr,
  byte_stream_if.src rd,
  output level_t     level_o
);

  // Block memory, no reset
  fifo_word_t mem [0:(1 << `USB_FIFO_ABITS)-1];

  // Pointers carry one extra wrap bit
  level_t     wr_ptr_q;
  level_t     rd_ptr_q;
  level_t     level_q;

  // Memory read register, then output register
  fifo_word_t ram_q;
  fifo_word_t out_q;
  logic       ram_valid_q;
  logic       out_valid_q;

  logic       wr_fire_w;
  logic       rd_fire_w;
  logic       mem_empty_w;
  logic       advance_w;
  logic       fetch_w;

  // Full at 2048 stored words, top level bit set
  assign wr.ready  = ~level_q[`USB_FIFO_ABITS];
  assign wr_fire_w = wr.valid && wr.ready;
  assign rd_fire_w = out_valid_q && rd.ready;

  // Nothing left in memory beyond the read stages
  assign mem_empty_w = (wr_ptr_q == rd_ptr_q);

  // Read stage moves into output register when that is free or draining
  assign advance_w = ram_valid_q && (!out_valid_q || rd.ready);

  // Prefetch from memory whenever the read stage has room
  assign fetch_w = !mem_empty_w && (!ram_valid_q || advance_w);

  // Write port
  always_ff @(posedge clock) begin
    if (wr_fire_w) begin
      mem[wr_ptr_q[`USB_FIFO_ABITS-1:0]] <= wr.word;
    end
  end

  // Registered read port
  always_ff @(posedge clock) begin
    if (fetch_w) begin
      ram_q <= mem[rd_ptr_q[`USB_FIFO_ABITS-1:0]];
    end
  end

  // Output payload
  always_ff @(posedge clock) begin
    if (advance_w) begin
      out_q <= ram_q;
    end
  end

  // Pointers and stage flags
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      ram_valid_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (wr_fire_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fetch_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (fetch_w) begin
        ram_valid_q <= 1'b1;
      end else if (advance_w) begin
        ram_valid_q <= 1'b0;
      end
      if (advance_w) begin
        out_valid_q <= 1'b1;
      end else if (rd_fire_w) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Occupancy counts memory plus both read stages
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      level_q <= '0;
    end else begin
      case ({wr_fire_w, rd_fire_w})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign rd.valid = out_valid_q;
  assign rd.word  = out_q;
  assign level_o  = level_q;

endmodule

`default_nettype wire

// ==== logic/bulk_in_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_loop_consts.svh"

module bulk_in_port
  import usb_loop_pkg::*;
(
  input  logic       clock,
  input  logic       usb_reset,
  input  logic       configured_i,
  input  logic       blk_cycle_i,
  input  level_t     level_i,
  byte_stream_if.snk rd,
  output logic       in_valid_o,
  output logic       in_last_o,
  output byte_t      in_data_o,
  input  logic       in_ready_i,
  output logic       blk_in_ready_o,
  output logic       blk_out_ready_o
);

  logic blk_in_ready_q;
  logic blk_out_ready_q;
  logic in_ok_w;
  logic out_ok_w;

  // FIFO head shown to the IN endpoint only during a bulk cycle
  assign in_valid_o = rd.valid && blk_cycle_i;
  assign in_last_o  = rd.word.last;
  assign in_data_o  = rd.word.data;

  // Pop only when the core takes it inside a bulk cycle
  assign rd.ready = in_ready_i && blk_cycle_i;

  // Enough queued to start an IN transfer
  assign in_ok_w = configured_i && (level_i > level_t'(`USB_IN_READY_MIN));

  // Room left for another OUT packet
  assign out_ok_w = configured_i && (level_i < level_t'(`USB_OUT_READY_MAX));

  // Endpoint flags, one cycle behind level and configured
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      blk_in_ready_q  <= 1'b0;
      blk_out_ready_q <= 1'b0;
    end else begin
      blk_in_ready_q  <= in_ok_w;
      blk_out_ready_q <= out_ok_w;
    end
  end

  assign blk_in_ready_o  = blk_in_ready_q;
  assign blk_out_ready_o = blk_out_ready_q;

endmodule

`default_nettype wire

// ==== logic/status_leds.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_loop_consts.svh"

module status_leds
  import usb_loop_pkg::*;
(
  input  logic                  clock,
  input  logic                  usb_reset,
  input  logic                  usb_sof_i,
  input  logic                  crc_error_i,
  input  logic                  timeout_i,
  output logic [`USB_LED_W-1:0] leds_o
);

  logic [`USB_SOF_CNT_W-1:0] count_q;
  logic                      sof_q;
  logic                      crc_latch_q;
  logic                      timeout_latch_q;
  led_mode_e                 mode_q;
  logic                      blink_w;

  // Frame counter, bumps on SOF rising edge
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      count_q <= '0;
      sof_q   <= 1'b0;
    end else begin
      sof_q <= usb_sof_i;
      if (usb_sof_i && !sof_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Sticky error flags, held until reset
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      crc_latch_q     <= 1'b0;
      timeout_latch_q <= 1'b0;
      mode_q          <= LED_NORMAL;
    end else begin
      if (crc_error_i) begin
        crc_latch_q <= 1'b1;
        // First CRC error switches to the fault pattern
        mode_q      <= LED_CRC_FAULT;
      end
      if (timeout_i) begin
        timeout_latch_q <= 1'b1;
      end
    end
  end

  // Slow blink normally, short flashes after a CRC fault
  assign blink_w = (mode_q == LED_NORMAL) ? count_q[12] : (count_q[10] & count_q[11]);

  // LEDs are active low
  assign leds_o = {~count_q[0], ~timeout_latch_q, ~crc_latch_q, ~blink_w};

endmodule

`default_nettype wire

// ==== logic/usb_loopback_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_loop_consts.svh"

module usb_loopback_top
  import usb_loop_pkg::*;
(
  input  logic                  clock,
  input  logic                  usb_reset,

  // Core status
  input  logic                  configured_i,
  input  logic                  blk_cycle_i,

  // Bulk OUT from the host
  input  logic                  out_valid_i,
  input  logic                  out_last_i,
  input  byte_t                 out_data_i,
  output logic                  out_ready_o,

  // Bulk IN to the host
  output logic                  in_valid_o,
  output logic                  in_last_o,
  output byte_t                 in_data_o,
  input  logic                  in_ready_i,

  // Endpoint ready flags back to the core
  output logic                  blk_in_ready_o,
  output logic                  blk_out_ready_o,

  // Frame and error strobes
  input  logic                  usb_sof_i,
  input  logic                  crc_error_i,
  input  logic                  timeout_i,
  output logic [`USB_LED_W-1:0] leds_o
);

  // Slice to FIFO, FIFO to IN port
  byte_stream_if wr_stream ();
  byte_stream_if rd_stream ();

  level_t level_w;

  // OUT endpoint register slice
  bulk_out_port u_bulk_out (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .blk_cycle_i (blk_cycle_i),
    .out_valid_i (out_valid_i),
    .out_last_i  (out_last_i),
    .out_data_i  (out_data_i),
    .out_ready_o (out_ready_o),
    .wr          (wr_stream.src)
  );

  // Loop-back buffer
  loopback_fifo u_fifo (
    .clock     (clock),
    .usb_reset (usb_reset),
    .wr        (wr_stream.snk),
    .rd        (rd_stream.src),
    .level_o   (level_w)
  );

  // IN endpoint and ready flags
  bulk_in_port u_bulk_in (
    .clock           (clock),
    .usb_reset       (usb_reset),
    .configured_i    (configured_i),
    .blk_cycle_i     (blk_cycle_i),
    .level_i         (level_w),
    .rd              (rd_stream.snk),
    .in_valid_o      (in_valid_o),
    .in_last_o       (in_last_o),
    .in_data_o       (in_data_o),
    .in_ready_i      (in_ready_i),
    .blk_in_ready_o  (blk_in_ready_o),
    .blk_out_ready_o (blk_out_ready_o)
  );

  // Board LEDs
  status_leds u_status (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .usb_sof_i   (usb_sof_i),
    .crc_error_i (crc_error_i),
    .timeout_i   (timeout_i),
    .leds_o      (leds_o)
  );

endmodule

`default_nettype wire

// ==== dv/usb_loopback_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_loop_consts.svh"

module usb_loopback_tb
  import usb_loop_pkg::*;
();

  // Row kinds
  typedef enum logic {
    KIND_STREAM,
    KIND_LEDS
  } kind_e;

  // One stimulus row with duties in percent
  typedef struct packed {
    kind_e kind;
    int    n_bytes;
    int    pkt_len;
    int    blk_duty;
    int    in_duty;
    logic  cfg;
    int    exp_acc;
  } row_t;

  localparam int NUM_ROWS   = 7;
  localparam int FIFO_DEPTH = 1 << `USB_FIFO_ABITS;
  // FIFO plus the OUT register slice
  localparam int TOTAL_CAP  = FIFO_DEPTH + 1;

  logic                  clock;
  logic                  usb_reset;
  logic                  configured_i;
  logic                  blk_cycle_i;
  logic                  out_valid_i;
  logic                  out_last_i;
  byte_t                 out_data_i;
  logic                  out_ready_o;
  logic                  in_valid_o;
  logic                  in_last_o;
  byte_t                 in_data_o;
  logic                  in_ready_i;
  logic                  blk_in_ready_o;
  logic                  blk_out_ready_o;
  logic                  usb_sof_i;
  logic                  crc_error_i;
  logic                  timeout_i;
  logic [`USB_LED_W-1:0] leds_o;

  row_t       rows [NUM_ROWS];
  // Bytes accepted on OUT and not yet seen on IN
  fifo_word_t model_q [$];

  int errors;
  int checks;
  int cycle_count;
  int cycle_limit = 1_000_000;
  int total;
  int offered;
  int acc_cnt;
  int rel_cnt;
  int pkt_pos;
  int pkt_cur;
  int pkt_len_row;
  bit out_took;

  usb_loopback_top i_dut (
    .clock           (clock),
    .usb_reset       (usb_reset),
    .configured_i    (configured_i),
    .blk_cycle_i     (blk_cycle_i),
    .out_valid_i     (out_valid_i),
    .out_last_i      (out_last_i),
    .out_data_i      (out_data_i),
    .out_ready_o     (out_ready_o),
    .in_valid_o      (in_valid_o),
    .in_last_o       (in_last_o),
    .in_data_o       (in_data_o),
    .in_ready_i      (in_ready_i),
    .blk_in_ready_o  (blk_in_ready_o),
    .blk_out_ready_o (blk_out_ready_o),
    .usb_sof_i       (usb_sof_i),
    .crc_error_i     (crc_error_i),
    .timeout_i       (timeout_i),
    .leds_o          (leds_o)
  );

  // 10 ns clock
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Run limit
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Random high with the given percentage
  function automatic bit chance(input int duty);
    return ($urandom % 100) < duty;
  endfunction

  // Active-low LED pattern from count and latches
  function automatic logic [`USB_LED_W-1:0] led_expect(input int sofs, input bit crc,
                                                        input bit tmo);
    logic blink;
    // CRC fault gives short flashes
    blink = crc ? (sofs[10] & sofs[11]) : sofs[12];
    return {~sofs[0], ~tmo, ~crc, ~blink};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    end
  endtask

  task automatic require(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR %s at %0t", what, $time);
    end
  endtask

  // Handshakes that the coming edge will complete
  task automatic sample_edge();
    int         depth;
    bit         in_took;
    fifo_word_t head;
    fifo_word_t w;
    depth    = model_q.size();
    out_took = out_valid_i && out_ready_o;
    in_took  = in_valid_o && in_ready_i;
    // Nothing moves outside a bulk cycle
    if (!blk_cycle_i) begin
      require(!out_ready_o, "OUT endpoint ready outside a bulk cycle");
      require(!in_valid_o, "IN endpoint offered a byte outside a bulk cycle");
    end
    if (in_took) begin
      require(depth > 0, "IN byte released with nothing queued");
      if (depth > 0) begin
        head = model_q.pop_front();
        compare_value("in_data_o", 32'(in_data_o), 32'(head.data));
        compare_value("in_last_o", 32'(in_last_o), 32'(head.last));
      end
      rel_cnt++;
    end
    if (out_took) begin
      require(depth < TOTAL_CAP, "OUT byte accepted while FIFO and slice were full");
      w.last = out_last_i;
      w.data = out_data_i;
      model_q.push_back(w);
      acc_cnt++;
    end
  endtask

  // Drive on the rising edge and sample on the falling edge
  task automatic drive_cycle(input int blk_duty, input int in_duty, input bit offer_en);
    @(posedge clock);
    blk_cycle_i <= chance(blk_duty);
    in_ready_i  <= chance(in_duty);
    // Held byte stays until taken
    if (out_took || !out_valid_i) begin
      if (offer_en && offered < total) begin
        if (pkt_pos == 0) begin
          pkt_cur = (pkt_len_row == 0) ? int'($urandom_range(64, 1)) : pkt_len_row;
        end
        out_valid_i <= 1'b1;
        out_data_i  <= 8'($urandom);
        out_last_i  <= (pkt_pos == pkt_cur - 1);
        pkt_pos = (pkt_pos == pkt_cur - 1) ? 0 : pkt_pos + 1;
        offered++;
      end else begin
        out_valid_i <= 1'b0;
      end
    end
    @(negedge clock);
    sample_edge();
  endtask

  // Let the slice drain and the flags register before comparing
  task automatic check_flags(input logic cfg);
    int   lvl;
    logic want_in;
    logic want_out;
    repeat (6) drive_cycle(0, 0, 1'b0);
    lvl      = (model_q.size() > FIFO_DEPTH) ? FIFO_DEPTH : model_q.size();
    want_in  = cfg && (lvl > `USB_IN_READY_MIN);
    want_out = cfg && (lvl < `USB_OUT_READY_MAX);
    compare_value("blk_in_ready_o", 32'(blk_in_ready_o), 32'(want_in));
    compare_value("blk_out_ready_o", 32'(blk_out_ready_o), 32'(want_out));
  endtask

  task automatic run_stream_row(input int idx);
    row_t r;
    int   idle;
    int   err0;
    int   drain_in;
    r           = rows[idx];
    err0        = errors;
    total       = r.n_bytes;
    offered     = 0;
    acc_cnt     = 0;
    rel_cnt     = 0;
    pkt_pos     = 0;
    pkt_len_row = r.pkt_len;
    out_took    = 1'b0;
    idle        = 0;
    @(posedge clock);
    configured_i <= r.cfg;
    @(negedge clock);
    sample_edge();
    // Send until all taken or OUT stops answering
    while (acc_cnt < total && idle < 64) begin
      drive_cycle(r.blk_duty, r.in_duty, 1'b1);
      idle = out_took ? 0 : idle + 1;
    end
    compare_value("out handshakes", 32'(acc_cnt), 32'(r.exp_acc));
    check_flags(r.cfg);
    // Stalled rows open IN for the drain
    drain_in = (r.in_duty == 0) ? 100 : r.in_duty;
    while (acc_cnt < total || model_q.size() > 0) begin
      drive_cycle(r.blk_duty, drain_in, 1'b1);
    end
    check_flags(r.cfg);
    compare_value("in handshakes", 32'(rel_cnt), 32'(acc_cnt));
    $display("test %0d stream: %0d bytes out, %0d bytes in, %0d errors",
             idx, acc_cnt, rel_cnt, errors - err0);
  endtask

  // 0 is CRC error, 1 is timeout, else SOF
  task automatic pulse_strobe(input int which);
    @(posedge clock);
    case (which)
      0:       crc_error_i <= 1'b1;
      1:       timeout_i   <= 1'b1;
      default: usb_sof_i   <= 1'b1;
    endcase
    @(posedge clock);
    crc_error_i <= 1'b0;
    timeout_i   <= 1'b0;
    usb_sof_i   <= 1'b0;
    @(negedge clock);
  endtask

  task automatic check_leds(input int sofs, input bit crc, input bit tmo);
    repeat (2) @(posedge clock);
    @(negedge clock);
    compare_value("leds_o", 32'(leds_o), 32'(led_expect(sofs, crc, tmo)));
  endtask

  task automatic apply_reset();
    @(posedge clock);
    usb_reset <= 1'b1;
    repeat (4) @(posedge clock);
    usb_reset <= 1'b0;
    @(negedge clock);
    model_q.delete();
    out_took = 1'b0;
  endtask

  task automatic run_led_row(input int idx);
    int err0;
    int sofs;
    err0 = errors;
    sofs = 0;
    check_leds(0, 1'b0, 1'b0);
    pulse_strobe(0);
    check_leds(0, 1'b1, 1'b0);
    pulse_strobe(1);
    check_leds(0, 1'b1, 1'b1);
    // Bit 3 follows count parity while both latches hold
    repeat (20) begin
      pulse_strobe(2);
      sofs++;
      check_leds(sofs, 1'b1, 1'b1);
    end
    apply_reset();
    check_leds(0, 1'b0, 1'b0);
    $display("test %0d leds: %0d SOF pulses, %0d errors", idx, sofs, errors - err0);
  endtask

  initial begin
    int limit_bytes;
    void'($urandom(32'h0548_0ab3));
    // kind, bytes, packet length (0 random), blk duty, in duty, configured, accepts
    rows[0] = '{KIND_STREAM, 400, 0, 50, 50, 1'b1, 400};
    rows[1] = '{KIND_STREAM, 300, 16, 100, 100, 1'b1, 300};
    rows[2] = '{KIND_STREAM, 3, 1, 50, 0, 1'b1, 3};
    rows[3] = '{KIND_STREAM, 1030, 64, 100, 0, 1'b1, 1030};
    rows[4] = '{KIND_STREAM, 20, 8, 100, 0, 1'b0, 20};
    rows[5] = '{KIND_STREAM, 2050, 64, 100, 0, 1'b1, 2049};
    rows[6] = '{KIND_LEDS, 0, 0, 0, 0, 1'b1, 0};
    limit_bytes = 0;
    foreach (rows[i]) begin
      limit_bytes += rows[i].n_bytes;
    end
    cycle_limit  = limit_bytes * 8 + 5000;
    errors       = 0;
    checks       = 0;
    cycle_count  = 0;
    out_took     = 1'b0;
    // Configured and inside a bulk cycle so the reset values below are not masked
    configured_i = 1'b1;
    blk_cycle_i  = 1'b1;
    out_valid_i  = 1'b0;
    out_last_i   = 1'b0;
    out_data_i   = '0;
    in_ready_i   = 1'b0;
    usb_sof_i    = 1'b0;
    crc_error_i  = 1'b0;
    timeout_i    = 1'b0;
    usb_reset    = 1'b1;
    repeat (4) @(posedge clock);
    usb_reset <= 1'b0;
    @(negedge clock);
    // Quiet state out of reset
    compare_value("in_valid_o", 32'(in_valid_o), 32'h0);
    compare_value("blk_in_ready_o", 32'(blk_in_ready_o), 32'h0);
    compare_value("blk_out_ready_o", 32'(blk_out_ready_o), 32'h0);
    compare_value("leds_o", 32'(leds_o), 32'(led_expect(0, 1'b0, 1'b0)));
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].kind == KIND_STREAM) begin
        run_stream_row(i);
      end else begin
        run_led_row(i);
      end
    end
    $display("tests %0d, checks %0d, errors %0d, cycles %0d",
             NUM_ROWS, checks, errors, cycle_count);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/usb_loop_pkg.sv
logic/byte_stream_if.sv
logic/bulk_out_port.sv
logic/loopback_fifo.sv
logic/bulk_in_port.sv
logic/status_leds.sv
logic/usb_loopback_top.sv
dv/usb_loopback_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loop-back testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module usb_loopback_tb -f flist.f -Mdir obj_dir -o usb_loopback_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/usb_loopback_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "Simulation log has no result line"
  exit 1
fi
exit 0
